/* Bender.yml */
package:
  name: keypad_text

sources:
  - src/keypad_pkg.sv
  - src/letter_encoder.sv
  - src/key_scanner.sv
  - src/multitap_controller.sv
  - src/keypad_text_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/keypad_model.sv
      - bench/tb_keypad_text.sv

/* bench/keypad_model.sv */
`timescale 1ns/1ps

module keypad_model (
  input  keypad_pkg::row_lines_t scan_col,  // Column drive from the DUT
  input  logic                   pressed,   // Key held down
  input  keypad_pkg::key_event_t key,       // Which key is held
  output keypad_pkg::row_lines_t read_row   // Row sense back to the DUT
);
  import keypad_pkg::*;

  row_lines_t col_line;  // Column of the held key as a line
  row_lines_t row_line;  // Row of the held key as a line
  logic       col_hit;

  // Index i sits on bit 3-i
  assign col_line = 4'b1000 >> key.col;
  assign row_line = 4'b1000 >> key.row;

  assign col_hit = |(scan_col & col_line);  // Our column is being driven

  // Switch closes the row onto the driven column
  assign read_row = (pressed && col_hit) ? row_line : '0;

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD       = 100,  // Clock period in ns
  parameter int RESET_CYCLES = 4     // Cycles with nRst low
) (
  output logic clk,
  output logic nRst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset released on a rising edge
  initial begin
    nRst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    nRst <= 1'b1;
  end

endmodule

/* bench/tb_keypad_text.sv */
`timescale 1ns/1ps

module tb_keypad_text;
  import keypad_pkg::*;

  localparam int WAIT_LIMIT = 200;  // Cycles before any wait gives up

  logic       clk;
  logic       nRst;
  row_lines_t read_row;
  row_lines_t scan_col;
  logic       char_ready;
  ascii_t     char_out;
  ascii_t     preview;
  logic       char_valid;
  logic       preview_valid;
  key_event_t held_key;   // Key the keypad model holds down
  logic       key_down;
  int         ready_run;  // Cycles left in the current char_ready stretch
  row_lines_t col_seen;   // scan_col as it was on the last edge

  // Reference model
  multitap_state_t m_st;
  key_event_t      m_key;      // Pending letter key
  int              m_taps;     // Presses of it so far, minus one
  ascii_t          m_preview;
  ascii_t          m_char;     // Character expected on the output

  int letter_rows[8] = '{0, 0, 1, 1, 1, 2, 2, 2};
  int letter_cols[8] = '{1, 2, 0, 1, 2, 0, 1, 2};

  tb_clock #(.PERIOD(100), .RESET_CYCLES(4)) i_tb_clock (.clk(clk), .nRst(nRst));

  keypad_model i_keypad_model (
    .scan_col (scan_col),
    .pressed  (key_down),
    .key      (held_key),
    .read_row (read_row)
  );

  keypad_text_top #(.SYNC_STAGES(2)) i_keypad_text_top (
    .clk           (clk),
    .nRst          (nRst),
    .read_row      (read_row),
    .char_ready    (char_ready),
    .scan_col      (scan_col),
    .char_out      (char_out),
    .char_valid    (char_valid),
    .preview       (preview),
    .preview_valid (preview_valid)
  );

  // Phone layout, zero for keys without letters
  function automatic ascii_t first_letter(input int r, input int c);
    case (r * 4 + c)
      1: return "A";
      2: return "D";
      4: return "G";
      5: return "J";
      6: return "M";
      8: return "P";
      9: return "T";
      10: return "W";
      default: return 8'h00;
    endcase
  endfunction

  function automatic int letters_in_group(input int r, input int c);
    if (first_letter(r, c) == 8'h00)
      return 0;
    else if (r * 4 + c == 8 || r * 4 + c == 10)
      return 4;  // PQRS and WXYZ
    else
      return 3;
  endfunction

  // Column i on bit 3-i, columns follow 0 1 2 3 0
  function automatic row_lines_t next_column(input row_lines_t col);
    int idx;
    idx = 0;
    for (int i = 0; i < 4; i++) begin
      if (col[3-i])
        idx = i;
    end
    return row_lines_t'(4'b1000 >> ((idx + 1) % 4));
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    stop_run($sformatf("MISMATCH at %0t ns: %s expected 0x%0h, got 0x%0h",
                       $time, name, expected, actual));
  endtask

  // Hold a key until the controller takes it, then let go
  task automatic press_key(input int r, input int c);
    int   n;
    logic taken;
    n     = 0;
    taken = 1'b0;
    @(posedge clk);
    held_key <= '{row: key_idx_t'(r), col: key_idx_t'(c)};
    key_down <= 1'b1;
    while (!taken && n < WAIT_LIMIT) begin
      @(posedge clk);
      taken = i_keypad_text_top.key_valid && i_keypad_text_top.key_ready;
      n++;
    end
    if (!taken)
      stop_run($sformatf("key at row %0d column %0d was never accepted", r, c));
    key_down <= 1'b0;
    repeat (6) @(posedge clk);  // Let the synchronizer drain
  endtask

  task automatic tap_key(input int r, input int c, input int times);
    for (int i = 0; i < times; i++)
      press_key(r, c);
  endtask

  always @(posedge clk) begin
    col_seen <= scan_col;
  end

  // Expected behavior, updated on the same edges as the DUT
  always @(posedge clk or negedge nRst) begin : ref_model
    key_event_t k;
    int         size;
    if (!nRst) begin
      m_st      <= IDLE;
      m_key     <= '0;
      m_taps    <= 0;
      m_preview <= '0;
      m_char    <= '0;
    end else if (m_st == EMIT) begin
      if (char_ready)
        m_st <= IDLE;                      // Character handed over
    end else if (i_keypad_text_top.key_valid) begin
      k    = held_key;                     // Key the bench holds down
      size = letters_in_group(k.row, k.col);
      if (k.row == 3 && k.col == 1) begin
        m_st <= IDLE;                      // Clear
      end else if (k.row == 3 && k.col == 0) begin
        if (m_st == COMPOSE) begin
          m_st   <= EMIT;
          m_char <= m_preview;
        end
      end else if (size != 0) begin
        m_st <= COMPOSE;
        if (m_st == COMPOSE && k == m_key) begin
          m_taps    <= m_taps + 1;
          m_preview <= first_letter(k.row, k.col) + ascii_t'((m_taps + 1) % size);
        end else begin
          m_key     <= k;                  // New letter starts at its first tap
          m_taps    <= 0;
          m_preview <= first_letter(k.row, k.col);
        end
      end
    end
  end

  // Mostly ready, with random low stretches
  always @(posedge clk) begin
    if (ready_run == 0) begin
      ready_run  <= $urandom_range(6, 1);
      char_ready <= ($urandom_range(2, 0) != 0);
    end else begin
      ready_run <= ready_run - 1;
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    (!nRst && $past(!nRst)) |-> (!char_valid && !preview_valid && scan_col == '0))
    else stop_run("outputs not quiet during reset");

  a_scan_start: assert property (@(posedge clk) disable iff (!nRst)
    (scan_col == '0) |=> (scan_col == 4'b1000))
    else report_mismatch("scan_col", 4'b1000, $sampled(scan_col));

  a_scan_rotate: assert property (@(posedge clk) disable iff (!nRst)
    (scan_col != '0 && read_row == '0) |=> (scan_col == next_column(col_seen)))
    else report_mismatch("scan_col", next_column($sampled(col_seen)), $sampled(scan_col));

  a_scan_hold: assert property (@(posedge clk) disable iff (!nRst)
    (scan_col != '0 && read_row != '0) |=> $stable(scan_col))
    else stop_run("scan_col moved while a row was active");

  a_preview_valid: assert property (@(posedge clk) disable iff (!nRst)
    preview_valid == (m_st == COMPOSE))
    else report_mismatch("preview_valid", m_st == COMPOSE, $sampled(preview_valid));

  a_preview: assert property (@(posedge clk) disable iff (!nRst)
    preview_valid |-> (preview == m_preview))
    else report_mismatch("preview", m_preview, $sampled(preview));

  a_char_valid: assert property (@(posedge clk) disable iff (!nRst)
    char_valid == (m_st == EMIT))
    else report_mismatch("char_valid", m_st == EMIT, $sampled(char_valid));

  a_char: assert property (@(posedge clk) disable iff (!nRst)
    char_valid |-> (char_out == m_char))
    else report_mismatch("char_out", m_char, $sampled(char_out));

  a_char_hold: assert property (@(posedge clk) disable iff (!nRst)
    (char_valid && !char_ready) |=> (char_valid && $stable(char_out)))
    else stop_run("char_out changed or dropped before it was taken");

  initial begin
    int n;
    int pick;
    void'($urandom(66));
    char_ready = 1'b0;
    key_down   = 1'b0;
    held_key   = '0;
    ready_run  = 0;
    n = 0;
    while (!nRst && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (!nRst)
      stop_run("reset was never released");
    repeat (12) @(posedge clk);           // Free scan, no key down

    tap_key(0, 1, 4);                     // A B C then wrap to A
    press_key(3, 0);
    press_key(3, 0);                      // Nothing pending, nothing sent
    tap_key(2, 0, 2);
    press_key(0, 0);                      // Ignored keys mid-letter
    press_key(3, 3);
    tap_key(2, 0, 3);                     // Through S and wrap to P
    press_key(3, 0);
    press_key(3, 3);                      // Ignored in idle
    press_key(1, 0);
    press_key(1, 1);                      // Different key restarts at J
    press_key(3, 1);
    press_key(3, 0);                      // Cleared, so no character
    tap_key(2, 2, 3);
    tap_key(2, 1, 2);
    press_key(3, 0);

    // Random words under back-pressure
    for (int w = 0; w < 10; w++) begin
      pick = $urandom_range(7, 0);
      tap_key(letter_rows[pick], letter_cols[pick], $urandom_range(5, 1));
      press_key(3, 0);
    end

    n = 0;
    while (m_st == EMIT && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (m_st == EMIT) begin
      stop_run("last character was never taken from the output");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

/* keypad_text.f */
src/keypad_pkg.sv
src/letter_encoder.sv
src/key_scanner.sv
src/multitap_controller.sv
src/keypad_text_top.sv
bench/tb_clock.sv
bench/keypad_model.sv
bench/tb_keypad_text.sv

/* src/key_scanner.sv */
`timescale 1ns/1ps

module key_scanner #(
  parameter int SYNC_STAGES = 2              // Row synchronizer depth
) (
  input  logic                   clk,
  input  logic                   nRst,
  input  keypad_pkg::row_lines_t read_row,   // Raw rows from the matrix
  input  logic                   key_ready,
  output keypad_pkg::row_lines_t scan_col,   // Driven column, one-hot
  output keypad_pkg::key_event_t key,        // Held key event
  output logic                   key_valid
);
  import keypad_pkg::*;

  row_lines_t [SYNC_STAGES-1:0] row_sync;  // [0] nearest the pins
  row_lines_t                   row_dly;   // Last sync stage, one cycle late
  row_lines_t                   row_rise;
  row_lines_t                   scan_col_next;
  logic                         press_edge;

  // Column rotation
  always_comb begin
    if ((|read_row) && (scan_col != '0))
      scan_col_next = scan_col;                   // Hold column while a key is down
    else if (scan_col == '0)
      scan_col_next = 4'b1000;                    // Start at column 0
    else
      scan_col_next = {scan_col[0], scan_col[3:1]}; // Next column, wraps 3 -> 0
  end

  // Synchronizer chain plus delay stage for the edge detector
  always_ff @(posedge clk or negedge nRst) begin
    if (!nRst) begin
      row_sync <= '0;
      row_dly  <= '0;
      scan_col <= '0;                             // No column driven in reset
    end else begin
      row_sync[0] <= read_row;
      for (int i = 1; i < SYNC_STAGES; i++)
        row_sync[i] <= row_sync[i-1];
      row_dly  <= row_sync[SYNC_STAGES-1];
      scan_col <= scan_col_next;
    end
  end

  assign row_rise   = row_sync[SYNC_STAGES-1] & ~row_dly;
  assign press_edge = |row_rise;                  // New press on any row

  // Event valid, held until the controller takes it
  always_ff @(posedge clk or negedge nRst) begin
    if (!nRst) begin
      key_valid <= 1'b0;
    end else if (key_valid) begin
      if (key_ready)
        key_valid <= 1'b0;                        // Accepted
    end else if (press_edge) begin
      key_valid <= 1'b1;
    end
  end

  // Event payload, loaded only into an empty slot
  // Column is still held here because the row stays up through the sync chain
  always_ff @(posedge clk) begin
    if (press_edge && !key_valid) begin
      key.row <= line_to_idx(row_rise);
      key.col <= line_to_idx(scan_col);
    end
  end

  // Never two columns driven at once
  a_scan_onehot: assert property (
    @(posedge clk) disable iff (!nRst)
    $onehot0(scan_col)
  );

  // Held event does not change under back-pressure
  a_key_stable: assert property (
    @(posedge clk) disable iff (!nRst)
    (key_valid && !key_ready) |=> (key_valid && $stable(key))
  );

endmodule

/* src/keypad_pkg.sv */
package keypad_pkg;

  // Row sense and column drive lines, one-hot or zero
  // Index 0 sits on the MSB, so row/column i is bit 3-i
  typedef logic [3:0] row_lines_t;

  typedef logic [1:0] key_idx_t;  // Row or column index 0..3
  typedef logic [1:0] tap_t;      // Tap count within a letter group
  typedef logic [7:0] ascii_t;    // One ASCII character

  // One key on the 4x4 matrix
  typedef struct packed {
    key_idx_t row;
    key_idx_t col;
  } key_event_t;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,  // Nothing pending
    COMPOSE = 2'd1,  // Letter being chosen
    EMIT    = 2'd2   // Finished letter on the output
  } multitap_state_t;

  // Control keys on the bottom row
  localparam key_event_t KEY_SUBMIT = '{row: 2'd3, col: 2'd0};
  localparam key_event_t KEY_CLEAR  = '{row: 2'd3, col: 2'd1};

  // Index of the active line, lowest index wins if several are set
  function automatic key_idx_t line_to_idx(row_lines_t lines);
    key_idx_t idx;
    idx = '0;
    for (int i = 3; i >= 0; i--) begin
      if (lines[3-i])
        idx = key_idx_t'(i);
    end
    return idx;
  endfunction

endpackage

/* src/keypad_text_top.sv */
`timescale 1ns/1ps

module keypad_text_top #(
  parameter int SYNC_STAGES = 2                // Row synchronizer depth
) (
  input  logic                   clk,
  input  logic                   nRst,
  input  keypad_pkg::row_lines_t read_row,     // From keypad rows
  input  logic                   char_ready,
  output keypad_pkg::row_lines_t scan_col,     // To keypad columns
  output keypad_pkg::ascii_t     char_out,
  output logic                   char_valid,
  output keypad_pkg::ascii_t     preview,      // Letter being composed
  output logic                   preview_valid
);
  import keypad_pkg::*;

  // Scanner to controller key stream
  key_event_t key;
  logic       key_valid;
  logic       key_ready;

  key_scanner #(
    .SYNC_STAGES (SYNC_STAGES)
  ) i_key_scanner (
    .clk       (clk),
    .nRst      (nRst),
    .read_row  (read_row),
    .key_ready (key_ready),
    .scan_col  (scan_col),
    .key       (key),
    .key_valid (key_valid)
  );

  multitap_controller i_multitap_controller (
    .clk           (clk),
    .nRst          (nRst),
    .key           (key),
    .key_valid     (key_valid),
    .char_ready    (char_ready),
    .key_ready     (key_ready),
    .char_out      (char_out),
    .preview       (preview),
    .char_valid    (char_valid),
    .preview_valid (preview_valid)
  );

endmodule

/* src/letter_encoder.sv */
`timescale 1ns/1ps

module letter_encoder (
  input  keypad_pkg::key_event_t key,
  input  keypad_pkg::tap_t       tap,         // Taps so far, 0 = first letter
  output keypad_pkg::ascii_t     letter,      // Zero for non-letter keys
  output keypad_pkg::tap_t       group_size,  // Last valid tap of the group
  output logic                   is_letter
);
  import keypad_pkg::*;

  ascii_t first;  // First letter of the group

  // Key layout, {row, col}
  always_comb begin
    first      = '0;
    group_size = 2'd2;                // Most groups have three letters
    is_letter  = 1'b1;
    case ({key.row, key.col})
      4'b00_01: first = "A";
      4'b00_10: first = "D";
      4'b01_00: first = "G";
      4'b01_01: first = "J";
      4'b01_10: first = "M";
      4'b10_00: begin
        first      = "P";
        group_size = 2'd3;            // PQRS
      end
      4'b10_01: first = "T";
      4'b10_10: begin
        first      = "W";
        group_size = 2'd3;            // WXYZ
      end
      default: begin
        is_letter  = 1'b0;            // Control or unused key
        group_size = 2'd0;
      end
    endcase
  end

  // Letter within the group
  assign letter = is_letter ? ascii_t'(first + ascii_t'(tap)) : '0;

endmodule

/* src/multitap_controller.sv */
`timescale 1ns/1ps

module multitap_controller (
  input  logic                   clk,
  input  logic                   nRst,
  input  keypad_pkg::key_event_t key,
  input  logic                   key_valid,
  input  logic                   char_ready,
  output logic                   key_ready,
  output keypad_pkg::ascii_t     char_out,
  output keypad_pkg::ascii_t     preview,
  output logic                   char_valid,
  output logic                   preview_valid
);
  import keypad_pkg::*;

  multitap_state_t state, state_next;

  key_event_t pend_key;   // Key of the letter being composed
  tap_t       tap_q;      // Current tap in that group
  tap_t       pend_size;  // Last tap of that group
  tap_t       tap_next;   // Tap for the incoming key
  logic       same_key;
  logic       key_accept;
  logic       load_letter;
  logic       submit_take;

  // Encoder outputs for the incoming key
  ascii_t     enc_letter;
  tap_t       enc_size;
  logic       enc_is_letter;

  assign key_ready  = (state != EMIT);        // Stall the scanner while emitting
  assign key_accept = key_valid && key_ready;

  // Repeat press of the pending key advances, anything else restarts
  assign same_key = (state == COMPOSE) && (key == pend_key);
  always_comb begin
    if (!same_key)
      tap_next = '0;
    else if (tap_q == pend_size)
      tap_next = '0;                          // Wrap to first letter
    else
      tap_next = tap_q + 2'd1;
  end

  letter_encoder i_letter_encoder (
    .key        (key),
    .tap        (tap_next),
    .letter     (enc_letter),
    .group_size (enc_size),
    .is_letter  (enc_is_letter)
  );

  // Next state
  always_comb begin
    state_next  = state;
    load_letter = 1'b0;
    case (state)
      IDLE, COMPOSE: begin
        if (key_accept) begin
          if (key == KEY_CLEAR) begin
            state_next = IDLE;                // Drop pending letter
          end else if (key == KEY_SUBMIT) begin
            if (state == COMPOSE)
              state_next = EMIT;              // Ignored in IDLE
          end else if (enc_is_letter) begin
            state_next  = COMPOSE;
            load_letter = 1'b1;
          end
        end
      end
      EMIT: begin
        if (char_valid && char_ready)
          state_next = IDLE;                  // Character taken
      end
      default: state_next = IDLE;
    endcase
  end

  assign submit_take = (state == COMPOSE) && (state_next == EMIT);

  always_ff @(posedge clk or negedge nRst) begin
    if (!nRst) begin
      state     <= IDLE;
      pend_key  <= '0;
      tap_q     <= '0;
      pend_size <= '0;
    end else begin
      state <= state_next;
      if (load_letter) begin
        pend_key  <= key;
        tap_q     <= tap_next;
        pend_size <= enc_size;
      end
    end
  end

  // Preview follows each accepted letter key, char_out latches on submit
  always_ff @(posedge clk) begin
    if (load_letter)
      preview <= enc_letter;
    if (submit_take)
      char_out <= preview;
  end

  assign char_valid    = (state == EMIT);
  assign preview_valid = (state == COMPOSE);

  // Output stays put until the sink takes it
  a_char_stable: assert property (
    @(posedge clk) disable iff (!nRst)
    (char_valid && !char_ready) |=> (char_valid && $stable(char_out))
  );

  // Tap never runs past the group
  a_tap_range: assert property (
    @(posedge clk) disable iff (!nRst)
    (state == COMPOSE) |-> (tap_q <= pend_size)
  );

endmodule
